//--- source/ahb_lsram_pkg.sv
// AHB-Lite SRAM shared definitions

package ahb_lsram_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and sizes
   ////////////////////////////////////////////////////////////
   localparam int ahb_dwidth  = 32;
   localparam int ahb_awidth  = 32;
   localparam int lane_count  = 4;
   localparam int mem_depth   = 512;
   localparam int word_awidth = 9;

   // HTRANS encodings
   localparam logic [1:0] trn_idle   = 2'b00;
   localparam logic [1:0] trn_busy   = 2'b01;
   localparam logic [1:0] trn_nonseq = 2'b10;
   localparam logic [1:0] trn_seq    = 2'b11;

   // HBURST encodings
   localparam logic [2:0] burst_single = 3'b000;
   localparam logic [2:0] burst_incr   = 3'b001;
   localparam logic [2:0] burst_wrap4  = 3'b010;
   localparam logic [2:0] burst_incr4  = 3'b011;
   localparam logic [2:0] burst_wrap8  = 3'b100;
   localparam logic [2:0] burst_incr8  = 3'b101;
   localparam logic [2:0] burst_wrap16 = 3'b110;
   localparam logic [2:0] burst_incr16 = 3'b111;

   // HSIZE encodings up to the full word
   localparam logic [2:0] size_byte = 3'b000;
   localparam logic [2:0] size_half = 3'b001;
   localparam logic [2:0] size_word = 3'b010;

   localparam logic [1:0] resp_okay = 2'b00;

   // Transfer controller FSM states
   localparam logic [1:0] st_idle  = 2'b00;
   localparam logic [1:0] st_write = 2'b01;
   localparam logic [1:0] st_read  = 2'b10;

   ////////////////////////////////////////////////////////////
   // Address word as flat bytes or as word index and lane
   ////////////////////////////////////////////////////////////
   typedef union packed {
      logic [ahb_awidth-1:0] byte_addr;
      struct packed {
         logic [ahb_awidth-word_awidth-3:0] upper;
         logic [word_awidth-1:0]            word_idx;
         logic [1:0]                        lane;
      } split;
   } ahb_addr_u;

endpackage

//--- source/sram_lane.sv
// Byte-wide SRAM lane

`timescale 1ns/1ps

module sram_lane (
   input  logic                                HCLK,
   input  logic [ahb_lsram_pkg::word_awidth-1:0] word_idx,
   input  logic                                wen,
   input  logic                                ren,
   input  logic [7:0]                          wdata,
   output logic [7:0]                          rdata
);

   import ahb_lsram_pkg::*;

   logic [7:0] mem [mem_depth];

   // Write lands at the enabled edge
   always_ff @(posedge HCLK) begin
      if (wen) begin
         mem[word_idx] <= wdata;
      end
   end

   // One cycle read latency with the output held between reads
   always_ff @(posedge HCLK) begin
      if (ren) begin
         rdata <= mem[word_idx];
      end
   end

endmodule

//--- source/ahb_xfer_ctrl.sv
// AHB transfer controller

`timescale 1ns/1ps

module ahb_xfer_ctrl (
   input  logic                                HCLK,
   input  logic                                aresetn,
   input  logic                                HSEL,
   input  logic [1:0]                          HTRANS,
   input  logic                                HWRITE,
   input  logic [2:0]                          HSIZE,
   input  logic                                HREADYIN,
   input  ahb_lsram_pkg::ahb_addr_u            mem_addr,
   output logic                                HREADYOUT,
   output logic                                cmd_accept,
   output logic                                addr_advance,
   output logic                                read_active,
   output logic                                mem_ren,
   output logic [ahb_lsram_pkg::lane_count-1:0] lane_wen
);

   import ahb_lsram_pkg::*;

   logic [1:0] state;
   logic [1:0] state_nxt;
   logic [2:0] size_q;
   logic       hwrite_q;
   logic [1:0] htrans_q;
   logic       new_read;
   logic       end_xfer;
   logic       wr_strobe;

   ////////////////////////////////////////////////////////////
   // Acceptance and ready
   ////////////////////////////////////////////////////////////
   assign cmd_accept = HSEL & HREADYIN & HREADYOUT & (HTRANS == trn_nonseq);

   // One wait state while the first read word comes out of the SRAM
   assign HREADYOUT = ~new_read;

   // Bus goes idle or moves on to another slave
   assign end_xfer = (HTRANS == trn_idle) | ((HTRANS == trn_nonseq) & ~HSEL);

   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         new_read <= 1'b0;
         size_q   <= size_byte;
         hwrite_q <= 1'b0;
         htrans_q <= trn_idle;
      end else begin
         new_read <= cmd_accept & ~HWRITE;
         htrans_q <= HTRANS;
         if (cmd_accept) begin
            size_q   <= HSIZE;
            hwrite_q <= HWRITE;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Idle / write / read FSM
   ////////////////////////////////////////////////////////////
   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (cmd_accept) begin
               state_nxt = HWRITE ? st_write : st_read;
            end
         end
         st_write, st_read: begin
            if (end_xfer) begin
               state_nxt = st_idle;
            end else if (cmd_accept) begin
               state_nxt = HWRITE ? st_write : st_read;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   assign read_active  = (state == st_read);
   assign mem_ren      = read_active;
   // Counter runs one beat ahead of the data phase
   assign addr_advance = read_active & (HTRANS == trn_seq);

   ////////////////////////////////////////////////////////////
   // Byte-lane write enables
   ////////////////////////////////////////////////////////////
   assign wr_strobe = (state == st_write) & hwrite_q & (htrans_q != trn_busy);

   always_comb begin
      lane_wen = '0;
      if (wr_strobe) begin
         case (size_q)
            size_byte: lane_wen[mem_addr.split.lane] = 1'b1;
            size_half: lane_wen = mem_addr.split.lane[1] ? 4'b1100 : 4'b0011;
            // Word, and anything wider than the bus
            default:   lane_wen = '1;
         endcase
      end
   end

endmodule

//--- source/burst_addr_gen.sv
// Burst address generator

`timescale 1ns/1ps

module burst_addr_gen (
   input  logic                     HCLK,
   input  logic                     aresetn,
   input  ahb_lsram_pkg::ahb_addr_u HADDR,
   input  logic [2:0]               HBURST,
   input  logic [2:0]               HSIZE,
   input  logic                     cmd_accept,
   input  logic                     addr_advance,
   input  logic                     read_active,
   output ahb_lsram_pkg::ahb_addr_u mem_addr
);

   import ahb_lsram_pkg::*;

   ahb_addr_u             addr_q;
   ahb_addr_u             rd_cnt;
   logic [ahb_awidth-1:0] incr;
   logic [ahb_awidth-1:0] wrap_mask;
   logic                  wrap_en;
   logic                  wrap_last;

   ////////////////////////////////////////////////////////////
   // Write path holds the address of the current data phase
   ////////////////////////////////////////////////////////////
   always_ff @(posedge HCLK) begin
      addr_q <= HADDR;
   end

   ////////////////////////////////////////////////////////////
   // Burst parameters captured at acceptance
   ////////////////////////////////////////////////////////////
   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         incr      <= '0;
         wrap_mask <= '0;
         wrap_en   <= 1'b0;
      end else if (cmd_accept) begin
         incr <= {{(ahb_awidth-1){1'b0}}, 1'b1} << HSIZE;
         // Beat-select bits inside the wrap block of beats x size bytes
         wrap_mask <= ((32'd2 << HBURST[2:1]) << HSIZE) - (32'd1 << HSIZE);
         case (HBURST)
            burst_wrap4, burst_wrap8, burst_wrap16: wrap_en <= 1'b1;
            default:                                wrap_en <= 1'b0;
         endcase
      end
   end

   // Counter sits on the last beat of its wrap block
   assign wrap_last = wrap_en & ((rd_cnt.byte_addr & wrap_mask) == wrap_mask);

   ////////////////////////////////////////////////////////////
   // Run-ahead read counter
   ////////////////////////////////////////////////////////////
   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         rd_cnt.byte_addr <= '0;
      end else if (cmd_accept) begin
         rd_cnt <= HADDR;
      end else if (addr_advance) begin
         if (wrap_last) begin
            // Back to the start of the block
            rd_cnt.byte_addr <= rd_cnt.byte_addr & ~wrap_mask;
         end else begin
            rd_cnt.byte_addr <= rd_cnt.byte_addr + incr;
         end
      end
   end

   assign mem_addr = read_active ? rd_cnt : addr_q;

endmodule

//--- source/ahb_lsram_top.sv
// AHB-Lite SRAM slave top level

`timescale 1ns/1ps

module ahb_lsram_top (
   input  logic                                HCLK,
   input  logic                                aresetn,
   input  logic                                HSEL,
   input  logic [1:0]                          HTRANS,
   input  logic [2:0]                          HBURST,
   input  logic                                HWRITE,
   input  logic [2:0]                          HSIZE,
   input  logic [ahb_lsram_pkg::ahb_awidth-1:0] HADDR,
   input  logic [ahb_lsram_pkg::ahb_dwidth-1:0] HWDATA,
   input  logic                                HREADYIN,
   output logic                                HREADYOUT,
   output logic [1:0]                          HRESP,
   output logic [ahb_lsram_pkg::ahb_dwidth-1:0] HRDATA
);

   import ahb_lsram_pkg::*;

   logic                           cmd_accept;
   logic                           addr_advance;
   logic                           read_active;
   logic                           mem_ren;
   logic [lane_count-1:0]          lane_wen;
   ahb_addr_u                      mem_addr;
   logic [lane_count-1:0][7:0]     lane_rdata;

   assign HRESP = resp_okay;

   ////////////////////////////////////////////////////////////
   // Control and addressing
   ////////////////////////////////////////////////////////////
   ahb_xfer_ctrl u_ctrl (
      .HCLK         (HCLK),
      .aresetn      (aresetn),
      .HSEL         (HSEL),
      .HTRANS       (HTRANS),
      .HWRITE       (HWRITE),
      .HSIZE        (HSIZE),
      .HREADYIN     (HREADYIN),
      .mem_addr     (mem_addr),
      .HREADYOUT    (HREADYOUT),
      .cmd_accept   (cmd_accept),
      .addr_advance (addr_advance),
      .read_active  (read_active),
      .mem_ren      (mem_ren),
      .lane_wen     (lane_wen)
   );

   burst_addr_gen u_addr (
      .HCLK         (HCLK),
      .aresetn      (aresetn),
      .HADDR        (HADDR),
      .HBURST       (HBURST),
      .HSIZE        (HSIZE),
      .cmd_accept   (cmd_accept),
      .addr_advance (addr_advance),
      .read_active  (read_active),
      .mem_addr     (mem_addr)
   );

   ////////////////////////////////////////////////////////////
   // Byte lanes with lane 0 on the low byte
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < lane_count; i++) begin : lane_gen
      sram_lane u_lane (
         .HCLK     (HCLK),
         .word_idx (mem_addr.split.word_idx),
         .wen      (lane_wen[i]),
         .ren      (mem_ren),
         .wdata    (HWDATA[8*i +: 8]),
         .rdata    (lane_rdata[i])
      );
   end

   assign HRDATA = lane_rdata;

endmodule

//--- verif/ahb_lsram_sva.sv
// AHB-Lite SRAM protocol checks

`timescale 1ns/1ps

module ahb_lsram_sva (
   input logic       HCLK,
   input logic       aresetn,
   input logic       HSEL,
   input logic [1:0] HTRANS,
   input logic       HWRITE,
   input logic       HREADYIN,
   input logic       HREADYOUT,
   input logic [1:0] HRESP
);

   import ahb_lsram_pkg::*;

   int   fail_count = 0;
   logic wr_accept;

   assign wr_accept = HSEL & HREADYIN & HREADYOUT & HWRITE & (HTRANS == trn_nonseq);

   ////////////////////////////////////////////////////////////
   // Response and ready rules
   ////////////////////////////////////////////////////////////
   a_resp_okay: assert property (@(posedge HCLK) disable iff (!aresetn) HRESP == resp_okay)
      else begin
         fail_count++;
         $error("HRESP is not OKAY");
      end

   // Writes never stall
   a_write_ready: assert property (@(posedge HCLK) disable iff (!aresetn)
                                   wr_accept |=> HREADYOUT)
      else begin
         fail_count++;
         $error("HREADYOUT low in the data phase of a write");
      end

   // At most one wait state in a row
   a_single_wait: assert property (@(posedge HCLK) disable iff (!aresetn)
                                   !HREADYOUT |=> HREADYOUT)
      else begin
         fail_count++;
         $error("HREADYOUT low for two cycles in a row");
      end

endmodule

bind ahb_lsram_top ahb_lsram_sva u_sva (.*);

//--- verif/ahb_lsram_tb.sv
// AHB-Lite SRAM testbench

`timescale 1ns/1ps

module ahb_lsram_tb;

   import ahb_lsram_pkg::*;

   localparam int half_period = 4;
   localparam int wait_limit  = 16;

   logic        HCLK;
   logic        aresetn;
   logic        HSEL;
   logic [1:0]  HTRANS;
   logic [2:0]  HBURST;
   logic        HWRITE;
   logic [2:0]  HSIZE;
   logic [31:0] HADDR;
   logic [31:0] HWDATA;
   logic        HREADYIN;
   logic        HREADYOUT;
   logic [1:0]  HRESP;
   logic [31:0] HRDATA;
   // Byte-addressed mirror of the SRAM
   logic [7:0]  model_mem [mem_depth*lane_count];
   integer      seed;
   int          check_errs;
   int          timeout_errs;
   int          total_errs;

   ahb_lsram_top UUT (.*);

   initial begin
      HCLK = 1'b0;
      forever #half_period HCLK = ~HCLK;
   end

   function automatic logic [3:0] byte_enables(input logic [2:0] size, input logic [31:0] addr);
      case (size)
         size_byte: return 4'b0001 << addr[1:0];
         size_half: return addr[1] ? 4'b1100 : 4'b0011;
         default:   return 4'b1111;
      endcase
   endfunction

   // Write updates the mirror and read compares the enabled lanes
   task automatic model_access(input logic wr, input logic [2:0] size, input logic [31:0] addr,
                               input logic [31:0] data);
      logic [3:0]  be;
      logic [31:0] exp;
      logic [31:0] mask;
      int          base;
      int          j;
      be   = byte_enables(size, addr);
      base = addr[10:2] * lane_count;
      for (j = 0; j < lane_count; j++) begin
         if (wr && be[j]) begin
            model_mem[base+j] = data[8*j +: 8];
         end
         exp[8*j +: 8]  = model_mem[base+j];
         mask[8*j +: 8] = {8{be[j]}};
      end
      if (!wr) begin
         assert ((data & mask) == (exp & mask)) else begin
            check_errs++;
            $display("mismatch HRDATA at %h: expected %h, got %h", addr, exp & mask, data & mask);
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Pipelined burst with the address phase of beat i over data of i-1
   ////////////////////////////////////////////////////////////
   task automatic run_burst(input logic wr, input logic [2:0] burst, input logic [2:0] size,
                            input logic [31:0] start, input int beats, input int exp_waits);
      logic [31:0] addr [16];
      logic [31:0] wdata [16];
      logic [31:0] blk;
      logic [31:0] rdat;
      logic        rdy;
      int          waits;
      int          late_waits;
      int          tmo;
      int          i;
      blk        = beats << size;
      waits      = 0;
      late_waits = 0;
      for (i = 0; i < beats; i++) begin
         addr[i] = start + (i << size);
         if (burst == burst_wrap4 || burst == burst_wrap8 || burst == burst_wrap16) begin
            addr[i] = (start & ~(blk - 1)) | (addr[i] & (blk - 1));
         end
         wdata[i] = $random(seed);
      end
      HSEL   = 1'b1;
      HWRITE = wr;
      HBURST = burst;
      HSIZE  = size;
      HTRANS = trn_nonseq;
      HADDR  = addr[0];
      for (i = 0; i <= beats; i++) begin
         rdy = 1'b0;
         tmo = 0;
         while (!rdy && tmo < wait_limit) begin
            @(negedge HCLK);
            rdy  = HREADYOUT;
            rdat = HRDATA;
            if (!rdy) begin
               waits++;
               // Only the cycle after acceptance may stall
               if (i != 1) begin
                  late_waits++;
               end
            end
            tmo++;
            @(posedge HCLK);
         end
         if (!rdy) begin
            timeout_errs++;
            $display("timeout: HREADYOUT stayed low in the burst starting at %h", start);
            HTRANS = trn_idle;
            return;
         end
         if (i > 0) begin
            model_access(wr, size, addr[i-1], wr ? wdata[i-1] : rdat);
         end
         #1;
         HTRANS = (i + 1 < beats) ? trn_seq : trn_idle;
         if (i + 1 < beats) begin
            HADDR = addr[i+1];
         end
         if (i < beats) begin
            HWDATA = wdata[i];
         end
      end
      assert (waits == exp_waits && late_waits == 0) else begin
         check_errs++;
         $display("mismatch HREADYOUT waits at %h: expected %h, got %h (%h late)",
                  start, exp_waits, waits, late_waits);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      seed         = 98218;
      check_errs   = 0;
      timeout_errs = 0;
      aresetn      = 1'b0;
      HSEL         = 1'b0;
      HTRANS       = trn_idle;
      HBURST       = burst_single;
      HWRITE       = 1'b0;
      HSIZE        = size_word;
      HADDR        = '0;
      HWDATA       = '0;
      HREADYIN     = 1'b1;
      repeat (4) @(posedge HCLK);
      #1;
      aresetn = 1'b1;
      // NONSEQ without HSEL is not a transfer
      HTRANS = trn_nonseq;
      repeat (3) begin
         @(negedge HCLK);
         assert (HREADYOUT === 1'b1 && HRESP === resp_okay) else begin
            check_errs++;
            $display("mismatch HREADYOUT %h HRESP %h while idle: expected 1 and %h",
                     HREADYOUT, HRESP, resp_okay);
         end
         @(posedge HCLK);
         #1;
      end
      // Full words first and partial overwrites after
      run_burst(1'b1, burst_single, size_word, 32'h100, 1, 0);
      run_burst(1'b1, burst_single, size_word, 32'h104, 1, 0);
      run_burst(1'b1, burst_single, size_word, 32'h108, 1, 0);
      run_burst(1'b1, burst_single, size_half, 32'h102, 1, 0);
      run_burst(1'b1, burst_single, size_half, 32'h104, 1, 0);
      run_burst(1'b1, burst_single, size_byte, 32'h109, 1, 0);
      run_burst(1'b1, burst_single, size_byte, 32'h10b, 1, 0);
      run_burst(1'b1, burst_single, size_byte, 32'h100, 1, 0);
      run_burst(1'b0, burst_single, size_word, 32'h100, 1, 1);
      run_burst(1'b0, burst_single, size_word, 32'h104, 1, 1);
      run_burst(1'b0, burst_single, size_word, 32'h108, 1, 1);
      run_burst(1'b1, burst_incr4, size_word, 32'h200, 4, 0);
      run_burst(1'b0, burst_incr4, size_word, 32'h200, 4, 1);
      run_burst(1'b0, burst_wrap4, size_word, 32'h208, 4, 1);
      run_burst(1'b1, burst_incr8, size_half, 32'h302, 8, 0);
      run_burst(1'b0, burst_incr8, size_half, 32'h302, 8, 1);
      // Undefined length burst closed by IDLE cycles
      run_burst(1'b0, burst_incr, size_word, 32'h204, 3, 1);
      repeat (2) @(posedge HCLK);
      #1;
      assert (!UUT.read_active) else begin
         check_errs++;
         $display("controller still in the read state after IDLE cycles");
      end
      run_burst(1'b1, burst_single, size_word, 32'h310, 1, 0);
      run_burst(1'b0, burst_single, size_word, 32'h310, 1, 1);
      total_errs = check_errs + timeout_errs + UUT.u_sva.fail_count;
      $display("errors: %0d check, %0d timeout, %0d assertion",
               check_errs, timeout_errs, UUT.u_sva.fail_count);
      if (total_errs == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- build.f
source/ahb_lsram_pkg.sv
source/sram_lane.sv
source/ahb_xfer_ctrl.sv
source/burst_addr_gen.sv
source/ahb_lsram_top.sv
verif/ahb_lsram_sva.sv
verif/ahb_lsram_tb.sv
